/* fetch.f */
+incdir+include
logic/fetch_pkg.sv
logic/fetch_ctrl.sv
logic/icache_tags.sv
logic/icache_plru.sv
logic/icache_data.sv
logic/fetch_top.sv
test/fetch_asserts.sv
test/fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --assert --top-module fetch_tb -f fetch.f --Mdir obj_dir -o fetch_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/fetch_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$log"; then
    exit 1
fi
exit 0

/* test/fetch_tb.sv */
`timescale 1ns/100ps
`include "fetch_defines.svh"

module fetch_tb;
    import fetch_pkg::*;

    logic clk;
    logic rst;
    logic req_valid;
    logic req_ready;
    addr_t req_addr;
    logic flush;
    logic resp_valid;
    logic resp_ready;
    block_t resp_data;
    logic mem_req_valid;
    logic mem_req_ready;
    addr_t mem_req_addr;
    logic mem_req_word;
    logic mem_resp_valid;
    logic mem_resp_ready;
    block_t mem_resp_data;

    logic [31:0] lfsr;
    int mem_reqs;
    int fetch_count;
    addr_t last_mem_addr;
    logic last_mem_word;

    // reference cache state
    logic [`FETCH_WAYS-1:0] model_valid [`FETCH_SETS];
    tag_t model_tag [`FETCH_SETS][`FETCH_WAYS];
    plru_t model_tree [`FETCH_SETS];

    fetch_top dut0 (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // root picks the half and 1 means the upper choice
    function automatic way_t model_victim(input plru_t t);
        way_t v;
        logic [2:0] leaf;
        v[2] = t[0];
        v[1] = v[2] ? t[2] : t[1];
        leaf = 3'd3 + {1'b0, v[2], v[1]};
        v[0] = t[leaf];
        return v;
    endfunction

    function automatic plru_t model_touch(input plru_t t, input way_t w);
        plru_t n;
        logic [2:0] leaf;
        n = t;
        leaf = 3'd3 + {1'b0, w[2], w[1]};
        n[0] = ~w[2];
        if (w[2]) begin
            n[2] = ~w[1];
        end else begin
            n[1] = ~w[1];
        end
        n[leaf] = ~w[0];
        return n;
    endfunction

    // returns the predicted hit and updates the model when apply is set
    function automatic logic model_access(input addr_t a, input logic apply);
        index_t set;
        tag_t tag;
        way_t way;
        way_t wi;
        logic hit;
        logic found;
        set = a[8:3];
        tag = a[31:9];
        hit = 1'b0;
        found = 1'b0;
        way = model_victim(model_tree[set]);
        for (int w = 0; w < `FETCH_WAYS; w++) begin
            wi = way_t'(w);
            if (!found && !model_valid[set][wi]) begin
                way = wi;
                found = 1'b1;
            end
        end
        for (int w = 0; w < `FETCH_WAYS; w++) begin
            wi = way_t'(w);
            if (model_valid[set][wi] && model_tag[set][wi] == tag) begin
                hit = 1'b1;
                way = wi;
            end
        end
        if (apply) begin
            model_valid[set][way] = 1'b1;
            model_tag[set][way] = tag;
            model_tree[set] = model_touch(model_tree[set], way);
        end
        return hit;
    endfunction

    task automatic fetch_and_check(input addr_t addr, input int stall_bits);
        logic cached;
        logic exp_hit;
        addr_t blk_addr;
        block_t exp_data;
        block_t held;
        int reqs_before;
        int resp_edge;
        int stall;
        cached = addr[`FETCH_UNCACHED_BIT];
        exp_hit = cached && model_access(addr, 1'b0);
        blk_addr = cached ? {addr[31:3], 3'b000} : addr;
        exp_data = {2{blk_addr ^ 32'h5a5a_5a5a}};
        reqs_before = mem_reqs;
        fetch_count++;
        req_valid = 1'b1;
        req_addr = addr;
        while (!req_ready) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        // counts edges after acceptance until resp_valid is sampled high
        resp_edge = 1;
        while (!resp_valid) begin
            @(posedge clk);
            #2;
            resp_edge++;
        end
        if (exp_hit) begin
            check_eq("hit latency", 64'(resp_edge), 64'd2);
        end
        stall = take_bits(stall_bits);
        held = resp_data;
        repeat (stall) begin
            // a competing request that must not be taken
            req_valid = 1'b1;
            req_addr = addr ^ 32'h0000_0200;
            @(posedge clk);
            #2;
            check_eq("resp_valid", 64'(resp_valid), 64'd1);
            check_eq("resp_data", resp_data, held);
            check_eq("req_ready", 64'(req_ready), 64'd0);
        end
        resp_ready = 1'b1;
        @(posedge clk);
        #2;
        resp_ready = 1'b0;
        req_valid = 1'b0;
        check_eq("resp_data", held, exp_data);
        check_eq("memory requests", 64'(mem_reqs - reqs_before), 64'(!exp_hit));
        if (!exp_hit) begin
            check_eq("mem_req_addr", 64'(last_mem_addr), 64'(blk_addr));
            check_eq("mem_req_word", 64'(last_mem_word), 64'(!cached));
        end
        if (cached) begin
            void'(model_access(addr, 1'b1));
        end
    endtask

    function automatic addr_t conflict_addr(input int t);
        return 32'h8000_0028 | (32'(t) << 9);
    endfunction

    task automatic test_uncached();
        fetch_and_check(32'h0000_1234, 2);
        fetch_and_check(32'h0000_2006, 2);
    endtask

    task automatic test_reuse();
        fetch_and_check(32'h8000_0108, 2);
        fetch_and_check(32'h8000_010c, 2);
    endtask

    // nine tags in set 5 and then every one again
    task automatic test_set_conflict();
        for (int t = 1; t <= 9; t++) begin
            fetch_and_check(conflict_addr(t), 2);
        end
        for (int t = 1; t <= 9; t++) begin
            fetch_and_check(conflict_addr(t), 2);
        end
    endtask

    task automatic test_flush();
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        model_valid = '{default: '0};
        fetch_and_check(32'h8000_0108, 2);
        fetch_and_check(conflict_addr(3), 2);
        fetch_and_check(conflict_addr(9), 2);
    endtask

    task automatic test_backpressure();
        fetch_and_check(32'h8000_0108, 4);
        fetch_and_check(32'h8000_0400, 4);
        fetch_and_check(32'h0000_0040, 4);
    endtask

    initial begin : memory_model
        addr_t a;
        logic w;
        forever begin
            @(posedge clk);
            #2;
            if (mem_req_valid) begin
                check_eq("mem_resp_ready", 64'(mem_resp_ready), 64'd0);
                repeat (take_bits(2)) begin
                    @(posedge clk);
                    #2;
                end
                mem_req_ready = 1'b1;
                a = mem_req_addr;
                w = mem_req_word;
                @(posedge clk);
                #2;
                mem_req_ready = 1'b0;
                mem_reqs++;
                last_mem_addr = a;
                last_mem_word = w;
                repeat (take_bits(2)) begin
                    @(posedge clk);
                    #2;
                end
                mem_resp_valid = 1'b1;
                mem_resp_data = {2{a ^ 32'h5a5a_5a5a}};
                check_eq("mem_resp_ready", 64'(mem_resp_ready), 64'd1);
                @(posedge clk);
                #2;
                mem_resp_valid = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > 200 * (fetch_count + 1)) begin
                $display("timeout: run still busy after %0d cycles", cycles);
                $display("TEST RESULT: FAIL");
                $fatal(1, "watchdog expired");
            end
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        flush = 1'b0;
        resp_ready = 1'b0;
        mem_req_ready = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data = '0;
        lfsr = 32'h1c5c_de9a;
        mem_reqs = 0;
        fetch_count = 0;
        last_mem_addr = '0;
        last_mem_word = 1'b0;
        model_valid = '{default: '0};
        model_tree = '{default: '0};
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        check_eq("req_ready", 64'(req_ready), 64'd1);
        check_eq("resp_valid", 64'(resp_valid), 64'd0);
        check_eq("mem_req_valid", 64'(mem_req_valid), 64'd0);
        check_eq("mem_resp_ready", 64'(mem_resp_ready), 64'd0);
        test_uncached();
        test_reuse();
        test_set_conflict();
        test_flush();
        test_backpressure();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* test/fetch_asserts.sv */
`timescale 1ns/100ps

module fetch_asserts (
    input logic clk,
    input logic rst,
    input logic req_ready,
    input logic resp_valid,
    input logic resp_ready,
    input fetch_pkg::block_t resp_data,
    input logic mem_req_valid,
    input logic mem_req_ready,
    input fetch_pkg::addr_t mem_req_addr
);

    // response holds until it is taken
    assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_data))
        else $error("resp_valid or resp_data changed before the transfer");

    assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr))
        else $error("mem_req_valid or mem_req_addr changed before the transfer");

    // one fetch in flight
    assert property (@(posedge clk) disable iff (rst) !(req_ready && resp_valid))
        else $error("req_ready and resp_valid high together");

endmodule

bind fetch_top fetch_asserts u_asserts (
    .clk           (clk),
    .rst           (rst),
    .req_ready     (req_ready),
    .resp_valid    (resp_valid),
    .resp_ready    (resp_ready),
    .resp_data     (resp_data),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req_addr  (mem_req_addr)
);

/* logic/fetch_top.sv */
`timescale 1ns/100ps
`include "fetch_defines.svh"

module fetch_top (
    input  logic clk,
    input  logic rst,
    input  logic req_valid,
    output logic req_ready,
    input  fetch_pkg::addr_t req_addr,
    input  logic flush,
    output logic resp_valid,
    input  logic resp_ready,
    output fetch_pkg::block_t resp_data,
    output logic mem_req_valid,
    input  logic mem_req_ready,
    output fetch_pkg::addr_t mem_req_addr,
    output logic mem_req_word,
    input  logic mem_resp_valid,
    output logic mem_resp_ready,
    input  fetch_pkg::block_t mem_resp_data
);
    import fetch_pkg::*;

    addr_t cur_addr;
    block_t resp_block;
    block_t refill_block;
    block_t cache_block;

    tag_t cur_tag;
    index_t cur_index;
    logic uncached;

    logic lookup_en;
    logic fill_en;
    logic flush_en;
    logic data_load;
    logic hit;
    logic touch_en;
    way_t hit_way;
    way_t fill_way;
    way_t victim_way;
    way_t touch_way;

    assign cur_tag = cur_addr[`FETCH_OFFSET_BITS + `FETCH_INDEX_BITS +: `FETCH_TAG_BITS];
    assign cur_index = cur_addr[`FETCH_OFFSET_BITS +: `FETCH_INDEX_BITS];
    assign uncached = !cur_addr[`FETCH_UNCACHED_BIT];

    // uncached: 4-byte read at the exact address, else the aligned block
    assign mem_req_word = uncached;
    assign mem_req_addr = uncached ? cur_addr
                                   : {cur_addr[31:`FETCH_OFFSET_BITS], {`FETCH_OFFSET_BITS{1'b0}}};

    assign resp_data = resp_block;

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            cur_addr <= req_addr;
        end
    end

    // mem_resp_ready marks mem_wait, where the block comes from memory
    always_ff @(posedge clk) begin
        if (data_load) begin
            resp_block <= mem_resp_ready ? mem_resp_data : cache_block;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_resp_valid && mem_resp_ready) begin
            refill_block <= mem_resp_data;
        end
    end

    // plru follows hits in lookup and refills in fill
    assign touch_en = (lookup_en && hit) || fill_en;
    assign touch_way = fill_en ? fill_way : hit_way;

    fetch_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .flush          (flush),
        .uncached       (uncached),
        .hit            (hit),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .resp_ready     (resp_ready),
        .req_ready      (req_ready),
        .lookup_en      (lookup_en),
        .fill_en        (fill_en),
        .flush_en       (flush_en),
        .data_load      (data_load),
        .mem_req_valid  (mem_req_valid),
        .mem_resp_ready (mem_resp_ready),
        .resp_valid     (resp_valid)
    );

    icache_tags u_tags (
        .clk        (clk),
        .rst        (rst),
        .index      (cur_index),
        .tag        (cur_tag),
        .fill_en    (fill_en),
        .flush_en   (flush_en),
        .victim_way (victim_way),
        .hit        (hit),
        .hit_way    (hit_way),
        .fill_way   (fill_way)
    );

    icache_plru u_plru (
        .clk        (clk),
        .rst        (rst),
        .index      (cur_index),
        .touch_en   (touch_en),
        .touch_way  (touch_way),
        .victim_way (victim_way)
    );

    icache_data u_data (
        .clk     (clk),
        .index   (cur_index),
        .rd_way  (hit_way),
        .wr_en   (fill_en),
        .wr_way  (fill_way),
        .wr_data (refill_block),
        .rd_data (cache_block)
    );

endmodule

/* logic/icache_data.sv */
`timescale 1ns/100ps
`include "fetch_defines.svh"

module icache_data (
    input  logic clk,
    input  fetch_pkg::index_t index,
    input  fetch_pkg::way_t rd_way,
    input  logic wr_en,
    input  fetch_pkg::way_t wr_way,
    input  fetch_pkg::block_t wr_data,
    output fetch_pkg::block_t rd_data
);

    logic [$bits(wr_data)-1:0] blocks [`FETCH_SETS][`FETCH_WAYS];

    // read is combinational, same set as the tag lookup
    assign rd_data = blocks[index][rd_way];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            blocks[index][wr_way] <= wr_data;
        end
    end

endmodule

/* logic/icache_plru.sv */
`timescale 1ns/100ps
`include "fetch_defines.svh"

module icache_plru (
    input  logic clk,
    input  logic rst,
    input  fetch_pkg::index_t index,
    input  logic touch_en,
    input  fetch_pkg::way_t touch_way,
    output fetch_pkg::way_t victim_way
);
    import fetch_pkg::*;

    plru_t trees [`FETCH_SETS];
    plru_t cur_tree;
    plru_t touched_tree;

    logic [2:0] touch_mid;
    logic [2:0] touch_leaf;
    logic [2:0] victim_mid;
    logic [2:0] victim_leaf;

    assign cur_tree = trees[index];

    // node numbers along the path of the touched way
    assign touch_mid = 3'd1 + {2'b00, touch_way[2]};
    assign touch_leaf = 3'd3 + {1'b0, touch_way[2:1]};

    // point every node on the path away from the touched way
    always_comb begin
        touched_tree = cur_tree;
        touched_tree[0] = ~touch_way[2];
        touched_tree[touch_mid] = ~touch_way[1];
        touched_tree[touch_leaf] = ~touch_way[0];
    end

    // walk from the root where 1 selects the upper half
    assign victim_mid = 3'd1 + {2'b00, cur_tree[0]};
    assign victim_leaf = 3'd3 + {1'b0, cur_tree[0], cur_tree[victim_mid]};
    assign victim_way = {cur_tree[0], cur_tree[victim_mid], cur_tree[victim_leaf]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < `FETCH_SETS; s++) begin
                trees[s] <= '0;
            end
        end else if (touch_en) begin
            trees[index] <= touched_tree;
        end
    end

endmodule

/* logic/icache_tags.sv */
`timescale 1ns/100ps
`include "fetch_defines.svh"

module icache_tags (
    input  logic clk,
    input  logic rst,
    input  fetch_pkg::index_t index,
    input  fetch_pkg::tag_t tag,
    input  logic fill_en,
    input  logic flush_en,
    input  fetch_pkg::way_t victim_way,
    output logic hit,
    output fetch_pkg::way_t hit_way,
    output fetch_pkg::way_t fill_way
);
    import fetch_pkg::*;

    logic [`FETCH_WAYS-1:0] valid [`FETCH_SETS];
    tag_t tags [`FETCH_SETS][`FETCH_WAYS];

    logic [`FETCH_WAYS-1:0] set_valid;
    logic [`FETCH_WAYS-1:0] way_match;

    assign set_valid = valid[index];

    always_comb begin
        for (int w = 0; w < `FETCH_WAYS; w++) begin
            way_match[w] = set_valid[w] && (tags[index][w] == tag);
        end
    end

    assign hit = |way_match;

    // at most one way matches
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `FETCH_WAYS; w++) begin
            if (way_match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    // lowest invalid way wins, plru victim when the set is full
    always_comb begin
        fill_way = victim_way;
        for (int w = `FETCH_WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                fill_way = way_t'(w);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < `FETCH_SETS; s++) begin
                valid[s] <= '0;
            end
        end else if (flush_en) begin
            for (int s = 0; s < `FETCH_SETS; s++) begin
                valid[s] <= '0;
            end
        end else if (fill_en) begin
            valid[index][fill_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[index][fill_way] <= tag;
        end
    end

endmodule

/* logic/fetch_ctrl.sv */
`timescale 1ns/100ps

module fetch_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic req_valid,
    input  logic flush,
    input  logic uncached,
    input  logic hit,
    input  logic mem_req_ready,
    input  logic mem_resp_valid,
    input  logic resp_ready,
    output logic req_ready,
    output logic lookup_en,
    output logic fill_en,
    output logic flush_en,
    output logic data_load,
    output logic mem_req_valid,
    output logic mem_resp_ready,
    output logic resp_valid
);
    import fetch_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (req_valid) begin
                    state_next = lookup;
                end
            end
            lookup: begin
                if (hit && !uncached) begin
                    state_next = resp;
                end else begin
                    state_next = mem_req;
                end
            end
            mem_req: begin
                if (mem_req_ready) begin
                    state_next = mem_wait;
                end
            end
            mem_wait: begin
                if (mem_resp_valid) begin
                    // uncached data goes straight out, no refill
                    state_next = uncached ? resp : fill;
                end
            end
            fill: begin
                state_next = resp;
            end
            resp: begin
                if (resp_ready) begin
                    state_next = idle;
                end
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    assign req_ready = (state == idle);

    // a request in the same cycle takes priority over the flush
    assign flush_en = (state == idle) && flush && !req_valid;

    assign lookup_en = (state == lookup) && !uncached;
    assign fill_en = (state == fill);

    // response block from the data array on a hit, from memory otherwise
    assign data_load = (lookup_en && hit) || ((state == mem_wait) && mem_resp_valid);

    assign mem_req_valid = (state == mem_req);
    assign mem_resp_ready = (state == mem_wait);
    assign resp_valid = (state == resp);

endmodule

/* logic/fetch_pkg.sv */
`include "fetch_defines.svh"

package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [63:0] block_t;

    typedef logic [`FETCH_TAG_BITS-1:0] tag_t;
    typedef logic [`FETCH_INDEX_BITS-1:0] index_t;
    typedef logic [$clog2(`FETCH_WAYS)-1:0] way_t;

    // bit 0 root, bits 1..2 middle, bits 3..6 leaves
    typedef logic [`FETCH_WAYS-2:0] plru_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        mem_req,
        mem_wait,
        fill,
        resp
    } ctrl_state_t;

endpackage

/* include/fetch_defines.svh */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// cache geometry
`define FETCH_WAYS 8
`define FETCH_SETS 64

// address split: tag | index | offset
`define FETCH_OFFSET_BITS 3
`define FETCH_INDEX_BITS 6
`define FETCH_TAG_BITS 23

// bit 31 clear means the fetch bypasses the cache
`define FETCH_UNCACHED_BIT 31

`endif
